//--- files.f
hw/mips_pkg.sv
hw/control_unit.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/mips_core.sv
tests/mips_core_tb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - hw/mips_pkg.sv
  - hw/control_unit.sv
  - hw/register_file.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/result_stage.sv
  - hw/mips_core.sv
  - target: test
    files:
      - tests/mips_core_tb.sv

//--- tests/mips_core_tb.sv
`timescale 1ns/1ns

module mips_core_tb import mips_pkg::*; ();

	localparam int IN_DEPTH    = 4;
	localparam int OUT_CREDITS = 2;
	localparam int TIMEOUT     = 400;
	localparam int REC_BITS    = 1 + REG_BITS + XLEN;

	localparam logic [5:0] R_FNS [13] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
		FN_XOR, FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
	localparam logic [5:0] I_OPS [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
		OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

	logic                clk;
	logic                rst;
	logic                in_valid;
	logic [XLEN-1:0]     in_instr;
	logic [XLEN-1:0]     in_pc;
	logic                in_credit;
	logic                out_credit;
	logic                out_valid;
	logic                out_redirect;
	logic [REG_BITS-1:0] out_dest;
	logic [XLEN-1:0]     out_value;

	// Records are packed as {redirect, dest, value}
	logic [XLEN-1:0]     ref_regs [2**REG_BITS];
	logic [REC_BITS-1:0] exp_q [$];
	logic [REC_BITS-1:0] got_q [$];
	logic [XLEN-1:0]     pc;
	int                  in_credits;
	int                  owed;
	logic                gate_open;
	logic                prog_done;
	integer              seed;

	mips_core #(
		.IN_DEPTH    (IN_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) DUT (
		.clk          (clk),
		.rst          (rst),
		.in_valid     (in_valid),
		.in_instr     (in_instr),
		.in_pc        (in_pc),
		.in_credit    (in_credit),
		.out_credit   (out_credit),
		.out_valid    (out_valid),
		.out_redirect (out_redirect),
		.out_dest     (out_dest),
		.out_value    (out_value)
	);

	always #2 clk = ~clk;

	////////////////////
	// Credit models
	////////////////////
	always @(negedge clk)
	begin
		if (in_credit === 1'b1)
			in_credits++;
		if (!rst && out_valid === 1'b1)
		begin
			got_q.push_back({out_redirect, out_dest, out_value});
			owed++;
		end
	end

	// Receiver hands back one credit per cycle while the gate is open
	always @(posedge clk)
	begin
		#1;
		if (out_credit)
			owed--;
		out_credit = gate_open && (owed > 0);
	end

	////////////////////
	// Failure reporting and compares
	////////////////////
	task automatic stop_failed();
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic abort_run(input string why);
		$display("%s at %0t ns", why, $time);
		stop_failed();
	endtask

	task automatic report_mismatch(input string name, input logic [XLEN-1:0] expected,
		input logic [XLEN-1:0] actual);
		$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		stop_failed();
	endtask

	task automatic check_write(input logic [REG_BITS-1:0] exp_dest,
		input logic [XLEN-1:0] exp_value, input logic got_redirect,
		input logic [REG_BITS-1:0] got_dest, input logic [XLEN-1:0] got_value);
		if (got_redirect !== 1'b0)
			report_mismatch("out_redirect", 0, got_redirect);
		if (got_dest !== exp_dest)
			report_mismatch("out_dest", exp_dest, got_dest);
		if (got_value !== exp_value)
			report_mismatch("out_value", exp_value, got_value);
	endtask

	task automatic check_redirect(input logic [XLEN-1:0] exp_target, input logic got_redirect,
		input logic [XLEN-1:0] got_target);
		if (got_redirect !== 1'b1)
			report_mismatch("out_redirect", 1, got_redirect);
		if (got_target !== exp_target)
			report_mismatch("out_value (target)", exp_target, got_target);
	endtask

	////////////////////
	// Encoders
	////////////////////
	function automatic instr_u enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
		instr_u w;
		w.r = '{OP_RTYPE, rs, rt, rd, shamt, funct};
		return w;
	endfunction

	function automatic instr_u enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instr_u w;
		w.i = '{op, rs, rt, imm};
		return w;
	endfunction

	function automatic instr_u enc_j(input logic [25:0] index);
		instr_u w;
		w.j = '{OP_J, index};
		return w;
	endfunction

	// Reference model of the kept subset, one instruction at a time
	task automatic predict_record(input instr_u ins, input logic [XLEN-1:0] at_pc);
		logic [XLEN-1:0]     a;
		logic [XLEN-1:0]     b;
		logic [XLEN-1:0]     simm;
		logic [XLEN-1:0]     zimm;
		logic [XLEN-1:0]     nxt;
		logic [XLEN-1:0]     v;
		logic [REG_BITS-1:0] dest;
		logic                w;
		a    = ref_regs[ins.r.rs];
		b    = ref_regs[ins.r.rt];
		simm = {{16{ins.i.imm[15]}}, ins.i.imm};
		zimm = {16'b0, ins.i.imm};
		nxt  = at_pc + 32'd4;
		dest = (ins.r.opcode == OP_RTYPE) ? ins.r.rd : ins.i.rt;
		w    = 1'b1;
		v    = '0;
		case (ins.r.opcode)
			OP_RTYPE:
			begin
				case (ins.r.funct)
					FN_ADD, FN_ADDU: v = a + b;
					FN_SUB, FN_SUBU: v = a - b;
					FN_AND:  v = a & b;
					FN_OR:   v = a | b;
					FN_XOR:  v = a ^ b;
					FN_NOR:  v = ~(a | b);
					FN_SLT:  v = ($signed(a) < $signed(b)) ? 1 : 0;
					FN_SLTU: v = (a < b) ? 1 : 0;
					FN_SLL:  v = b << ins.r.shamt;
					FN_SRL:  v = b >> ins.r.shamt;
					FN_SRA:  v = $signed(b) >>> ins.r.shamt;
					default:
					begin
						w = 1'b0;
						if (ins.r.funct == FN_JR)
							exp_q.push_back({1'b1, {REG_BITS{1'b0}}, a});
					end
				endcase
			end
			OP_ADDI, OP_ADDIU: v = a + simm;
			OP_SLTI:  v = ($signed(a) < $signed(simm)) ? 1 : 0;
			OP_SLTIU: v = (a < simm) ? 1 : 0;
			OP_ANDI:  v = a & zimm;
			OP_ORI:   v = a | zimm;
			OP_XORI:  v = a ^ zimm;
			OP_LUI:   v = {ins.i.imm, 16'b0};
			default:
			begin
				// Branches and jumps write nothing, only taken ones redirect
				w = 1'b0;
				if ((ins.r.opcode == OP_BEQ && a == b) || (ins.r.opcode == OP_BNE && a != b))
					exp_q.push_back({1'b1, {REG_BITS{1'b0}}, nxt + (simm << 2)});
				else if (ins.r.opcode == OP_J)
					exp_q.push_back({1'b1, {REG_BITS{1'b0}}, nxt[31:28], ins.j.index, 2'b00});
			end
		endcase
		if (w && dest != '0)
		begin
			ref_regs[dest] = v;
			exp_q.push_back({1'b0, dest, v});
		end
	endtask

	task automatic send_instr(input instr_u ins, input logic [XLEN-1:0] at_pc);
		int waited;
		waited = 0;
		while (in_credits == 0)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > TIMEOUT)
				abort_run("Sender waited too long for an input credit");
		end
		in_valid = 1'b1;
		in_instr = ins;
		in_pc    = at_pc;
		in_credits--;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic exec_instr(input instr_u ins);
		predict_record(ins, pc);
		send_instr(ins, pc);
		pc = pc + 32'd4;
	endtask

	task automatic drain_and_check();
		int                  waited;
		logic [REC_BITS-1:0] e;
		logic [REC_BITS-1:0] g;
		waited = 0;
		while (got_q.size() < exp_q.size())
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > TIMEOUT)
				abort_run("Expected records did not all arrive");
		end
		while (exp_q.size() > 0)
		begin
			e = exp_q.pop_front();
			g = got_q.pop_front();
			if (e[REC_BITS-1])
				check_redirect(e[XLEN-1:0], g[REC_BITS-1], g[XLEN-1:0]);
			else
				check_write(e[XLEN +: REG_BITS], e[XLEN-1:0], g[REC_BITS-1],
					g[XLEN +: REG_BITS], g[XLEN-1:0]);
		end
		// Idle window to catch records that should never have been made
		repeat (6) @(posedge clk);
		#1;
		if (got_q.size() != 0)
			abort_run("Core produced a record that was not expected");
	endtask

	////////////////////
	// Directed tests
	////////////////////
	task automatic test_idle_and_credits();
		for (int i = 0; i < 8; i++)
		begin
			@(negedge clk);
			if (out_valid !== 1'b0)
				report_mismatch("out_valid", 0, out_valid);
			if (in_credit !== 1'b0)
				report_mismatch("in_credit", 0, in_credit);
		end
		@(posedge clk);
		#1;
		if (in_credits != IN_DEPTH)
			report_mismatch("sender credit count", IN_DEPTH, in_credits);
		// The last producer stays in the result slot and its readers fill the queue
		gate_open = 1'b0;
		for (int i = 1; i <= OUT_CREDITS + 1; i++)
			exec_instr(enc_i(OP_ORI, 0, i, 16'h0100 + i));
		for (int i = 0; i < IN_DEPTH; i++)
			exec_instr(enc_r(OUT_CREDITS + 1, 0, 24 + i, 0, FN_OR));
		for (int i = 0; i < 8; i++)
		begin
			@(negedge clk);
			if (in_credit !== 1'b0)
				report_mismatch("in_credit", 0, in_credit);
		end
		if (in_credits != 0)
			report_mismatch("sender credit count", 0, in_credits);
		gate_open = 1'b1;
		drain_and_check();
		if (in_credits != IN_DEPTH)
			report_mismatch("sender credit count", IN_DEPTH, in_credits);
	endtask

	task automatic test_r_ops();
		exec_instr(enc_i(OP_ADDI, 0, 5, $random(seed)));
		for (int r = 1; r <= 4; r++)
		begin
			exec_instr(enc_i(OP_LUI, 0, r, $random(seed)));
			exec_instr(enc_i(OP_ORI, r, r, $random(seed)));
		end
		for (int i = 0; i < 13; i++)
			exec_instr(enc_r(1 + i % 4, 1 + (i + 1) % 5, 16 + i, $random(seed), R_FNS[i]));
		drain_and_check();
	endtask

	task automatic test_chains();
		// Every instruction consumes the destination just before it
		for (int i = 0; i < 6; i++)
		begin
			exec_instr(enc_r(11, 1 + i % 4, 11, 0, FN_ADDU));
			exec_instr(enc_r(0, 11, 12, 1 + i, FN_SRA));
			exec_instr(enc_r(12, 11, 11, 0, FN_XOR));
		end
		drain_and_check();
	endtask

	task automatic test_immediates();
		exec_instr(enc_i(OP_ADDI, 0, 6, 16'h8001));
		exec_instr(enc_i(OP_ADDI, 6, 7, 16'hfff0));
		exec_instr(enc_i(OP_SLTI, 6, 8, 16'hffff));
		exec_instr(enc_i(OP_SLTI, 7, 9, 16'h0001));
		exec_instr(enc_i(OP_ANDI, 6, 10, 16'hf00f));
		exec_instr(enc_i(OP_ORI, 0, 13, 16'h8000));
		exec_instr(enc_i(OP_XORI, 6, 14, 16'hffff));
		exec_instr(enc_i(OP_LUI, 0, 15, 16'hbeef));
		exec_instr(enc_i(OP_ADDI, 1, 0, 16'h0005));
		exec_instr(enc_i(OP_LUI, 0, 0, 16'h1234));
		exec_instr(enc_r(0, 0, 20, 0, FN_OR));
		drain_and_check();
	endtask

	task automatic test_redirects();
		pc = 32'h4000_0100;
		exec_instr(enc_i(OP_ORI, 0, 14, 16'h0001));
		exec_instr(enc_i(OP_ORI, 0, 15, 16'h0002));
		exec_instr(enc_i(OP_BEQ, 14, 14, 16'h0010));
		exec_instr(enc_i(OP_BEQ, 14, 15, 16'h0020));
		exec_instr(enc_i(OP_BNE, 14, 15, 16'hfff8));
		exec_instr(enc_j(26'h2a5_5a5));
		exec_instr(enc_r(3, 0, 0, 0, FN_JR));
		drain_and_check();
	endtask

	task automatic run_random_program();
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		int          kind;
		for (int n = 0; n < 20; n++)
		begin
			kind = $random(seed) & 3;
			rs   = $random(seed) & 7;
			rt   = $random(seed) & 7;
			rd   = $random(seed) & 7;
			imm  = $random(seed);
			case (kind)
				0: exec_instr(enc_r(rs, rt, rd, imm[10:6], R_FNS[imm[15:12] % 13]));
				1: exec_instr(enc_i(I_OPS[imm[2:0]], rs, rt, imm));
				2: exec_instr(enc_i(imm[0] ? OP_BNE : OP_BEQ, rs, rt, imm));
				default: exec_instr(enc_i(OP_ADDIU, rs, rt, imm));
			endcase
		end
		prog_done = 1'b1;
	endtask

	task automatic test_credit_backpressure();
		int waited;
		gate_open = 1'b0;
		prog_done = 1'b0;
		fork
			run_random_program();
		join_none
		repeat (40) @(posedge clk);
		#1;
		if (got_q.size() > OUT_CREDITS)
			abort_run("Core sent more records than it held result credits for");
		gate_open = 1'b1;
		waited = 0;
		while (!prog_done)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > TIMEOUT)
				abort_run("Random program was not accepted after the receiver resumed");
		end
		drain_and_check();
	endtask

	initial
	begin
		seed         = 32'hb4a6_691c;
		clk          = 1'b0;
		rst          = 1'b1;
		in_valid     = 1'b0;
		in_instr     = '0;
		in_pc        = '0;
		out_credit   = 1'b0;
		gate_open    = 1'b1;
		prog_done    = 1'b0;
		in_credits   = IN_DEPTH;
		owed         = 0;
		pc           = 32'h0000_0400;
		for (int i = 0; i < 2**REG_BITS; i++)
			ref_regs[i] = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		test_idle_and_credits();
		test_r_ops();
		test_chains();
		test_immediates();
		test_redirects();
		test_credit_backpressure();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- hw/mips_core.sv
`timescale 1ns/1ns

module mips_core import mips_pkg::*; #(
	parameter int IN_DEPTH    = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  logic [XLEN-1:0]     in_instr,
	input  logic [XLEN-1:0]     in_pc,
	output logic                in_credit,
	input  logic                out_credit,
	output logic                out_valid,
	output logic                out_redirect,
	output logic [REG_BITS-1:0] out_dest,
	output logic [XLEN-1:0]     out_value
);

	// Decode to execute
	logic                ex_valid;
	logic [ALU_BITS-1:0] ex_alu_op;
	logic [XLEN-1:0]     ex_a;
	logic [XLEN-1:0]     ex_b;
	logic                ex_use_imm;
	logic [XLEN-1:0]     ex_imm;
	logic [4:0]          ex_shamt;
	logic [REG_BITS-1:0] ex_dest;
	logic                ex_writes;
	logic                ex_is_beq;
	logic                ex_is_bne;
	logic                ex_is_jump;
	logic [XLEN-1:0]     ex_target;
	logic                ex_hold;

	// Execute to result, and write-back
	logic                rs_valid;
	logic                rs_redirect;
	logic [REG_BITS-1:0] rs_dest;
	logic [XLEN-1:0]     rs_value;
	logic                res_hold;
	logic                wr_en;
	logic [REG_BITS-1:0] wr_dest;
	logic [XLEN-1:0]     wr_data;

	decode_stage #(
		.IN_DEPTH (IN_DEPTH)
	) u_decode (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_pc      (in_pc),
		.in_credit  (in_credit),
		.hold       (ex_hold),
		.wr_en      (wr_en),
		.wr_dest    (wr_dest),
		.wr_data    (wr_data),
		.ex_valid   (ex_valid),
		.ex_alu_op  (ex_alu_op),
		.ex_a       (ex_a),
		.ex_b       (ex_b),
		.ex_use_imm (ex_use_imm),
		.ex_imm     (ex_imm),
		.ex_shamt   (ex_shamt),
		.ex_dest    (ex_dest),
		.ex_writes  (ex_writes),
		.ex_is_beq  (ex_is_beq),
		.ex_is_bne  (ex_is_bne),
		.ex_is_jump (ex_is_jump),
		.ex_target  (ex_target)
	);

	execute_stage u_execute (
		.clk         (clk),
		.rst         (rst),
		.hold        (res_hold),
		.ex_valid    (ex_valid),
		.ex_alu_op   (ex_alu_op),
		.ex_a        (ex_a),
		.ex_b        (ex_b),
		.ex_use_imm  (ex_use_imm),
		.ex_imm      (ex_imm),
		.ex_shamt    (ex_shamt),
		.ex_dest     (ex_dest),
		.ex_writes   (ex_writes),
		.ex_is_beq   (ex_is_beq),
		.ex_is_bne   (ex_is_bne),
		.ex_is_jump  (ex_is_jump),
		.ex_target   (ex_target),
		.rs_valid    (rs_valid),
		.rs_redirect (rs_redirect),
		.rs_dest     (rs_dest),
		.rs_value    (rs_value),
		.ex_hold     (ex_hold)
	);

	result_stage #(
		.OUT_CREDITS (OUT_CREDITS)
	) u_result (
		.clk          (clk),
		.rst          (rst),
		.out_credit   (out_credit),
		.rs_valid     (rs_valid),
		.rs_redirect  (rs_redirect),
		.rs_dest      (rs_dest),
		.rs_value     (rs_value),
		.hold         (res_hold),
		.out_valid    (out_valid),
		.out_redirect (out_redirect),
		.out_dest     (out_dest),
		.out_value    (out_value),
		.wr_en        (wr_en),
		.wr_dest      (wr_dest),
		.wr_data      (wr_data)
	);

endmodule

//--- hw/result_stage.sv
`timescale 1ns/1ns

module result_stage import mips_pkg::*; #(
	parameter int OUT_CREDITS = 2
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                out_credit,
	input  logic                rs_valid,
	input  logic                rs_redirect,
	input  logic [REG_BITS-1:0] rs_dest,
	input  logic [XLEN-1:0]     rs_value,
	output logic                hold,
	output logic                out_valid,
	output logic                out_redirect,
	output logic [REG_BITS-1:0] out_dest,
	output logic [XLEN-1:0]     out_value,
	output logic                wr_en,
	output logic [REG_BITS-1:0] wr_dest,
	output logic [XLEN-1:0]     wr_data
);

	// One spare bit so an extra credit shows up instead of wrapping
	localparam int CRD_BITS = $clog2(OUT_CREDITS + 1) + 1;

	logic                slot_valid;
	logic [CRD_BITS-1:0] credits;

	assign out_valid = slot_valid && (credits != '0);
	assign hold      = slot_valid && !out_valid;

	// Write-back and scoreboard release go with the emitted record
	assign wr_en   = out_valid && !out_redirect;
	assign wr_dest = out_dest;
	assign wr_data = out_value;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			slot_valid <= 1'b0;
			credits    <= CRD_BITS'(OUT_CREDITS);
		end
		else
		begin
			if (!hold)
				slot_valid <= rs_valid;
			credits <= credits - CRD_BITS'(out_valid) + CRD_BITS'(out_credit);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!hold)
		begin
			out_redirect <= rs_redirect;
			out_dest     <= rs_dest;
			out_value    <= rs_value;
		end
	end

	// Receiver returns no more credits than records it was sent
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits <= CRD_BITS'(OUT_CREDITS));

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import mips_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                hold,
	input  logic                ex_valid,
	input  logic [ALU_BITS-1:0] ex_alu_op,
	input  logic [XLEN-1:0]     ex_a,
	input  logic [XLEN-1:0]     ex_b,
	input  logic                ex_use_imm,
	input  logic [XLEN-1:0]     ex_imm,
	input  logic [4:0]          ex_shamt,
	input  logic [REG_BITS-1:0] ex_dest,
	input  logic                ex_writes,
	input  logic                ex_is_beq,
	input  logic                ex_is_bne,
	input  logic                ex_is_jump,
	input  logic [XLEN-1:0]     ex_target,
	output logic                rs_valid,
	output logic                rs_redirect,
	output logic [REG_BITS-1:0] rs_dest,
	output logic [XLEN-1:0]     rs_value,
	output logic                ex_hold
);

	logic [XLEN-1:0] b_sel;
	logic [XLEN-1:0] alu_out;
	logic            taken;

	assign b_sel = ex_use_imm ? ex_imm : ex_b;

	always_comb
	begin
		case (ex_alu_op)
			ALU_SUB:  alu_out = ex_a - b_sel;
			ALU_AND:  alu_out = ex_a & b_sel;
			ALU_OR:   alu_out = ex_a | b_sel;
			ALU_XOR:  alu_out = ex_a ^ b_sel;
			ALU_NOR:  alu_out = ~(ex_a | b_sel);
			ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(ex_a) < $signed(b_sel)};
			ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, ex_a < b_sel};
			// Shifts act on rt by the shamt field
			ALU_SLL:  alu_out = ex_b << ex_shamt;
			ALU_SRL:  alu_out = ex_b >> ex_shamt;
			ALU_SRA:  alu_out = $signed(ex_b) >>> ex_shamt;
			ALU_LUI:  alu_out = {b_sel[15:0], 16'b0};
			default:  alu_out = ex_a + b_sel;
		endcase
	end

	// Branch compare uses the register operands, jumps always redirect
	assign taken = ex_is_jump || (ex_is_beq && ex_a == ex_b) || (ex_is_bne && ex_a != ex_b);

	// Only a full register is frozen by the result slot
	assign ex_hold = hold && rs_valid;

	always_ff @(posedge clk)
	begin
		if (rst)
			rs_valid <= 1'b0;
		else if (!ex_hold)
			rs_valid <= ex_valid && (ex_writes || taken);
	end

	always_ff @(posedge clk)
	begin
		if (!ex_hold)
		begin
			rs_redirect <= taken;
			rs_dest     <= taken ? '0 : ex_dest;
			rs_value    <= taken ? ex_target : alu_out;
		end
	end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import mips_pkg::*; #(
	parameter int IN_DEPTH = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  logic [XLEN-1:0]     in_instr,
	input  logic [XLEN-1:0]     in_pc,
	output logic                in_credit,
	input  logic                hold,
	input  logic                wr_en,
	input  logic [REG_BITS-1:0] wr_dest,
	input  logic [XLEN-1:0]     wr_data,
	output logic                ex_valid,
	output logic [ALU_BITS-1:0] ex_alu_op,
	output logic [XLEN-1:0]     ex_a,
	output logic [XLEN-1:0]     ex_b,
	output logic                ex_use_imm,
	output logic [XLEN-1:0]     ex_imm,
	output logic [4:0]          ex_shamt,
	output logic [REG_BITS-1:0] ex_dest,
	output logic                ex_writes,
	output logic                ex_is_beq,
	output logic                ex_is_bne,
	output logic                ex_is_jump,
	output logic [XLEN-1:0]     ex_target
);

	localparam int PTR_BITS = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(IN_DEPTH + 1);

	instr_u                  q_instr [IN_DEPTH];
	logic [XLEN-1:0]         q_pc [IN_DEPTH];
	logic [PTR_BITS-1:0]     wr_ptr;
	logic [PTR_BITS-1:0]     rd_ptr;
	logic [CNT_BITS-1:0]     q_count;
	logic [2**REG_BITS-1:0]  scoreboard;
	logic [2**REG_BITS-1:0]  pending;
	logic [2**REG_BITS-1:0]  set_mask;
	instr_u                  head;
	logic [XLEN-1:0]         head_pc;
	logic [XLEN-1:0]         pc_plus4;
	logic [XLEN-1:0]         imm_ext;
	logic [XLEN-1:0]         rs_data;
	logic [XLEN-1:0]         rt_data;
	logic [REG_BITS-1:0]     dest;
	logic [ALU_BITS-1:0]     alu_op;
	logic use_imm, zero_ext, writes, dest_is_rd;
	logic is_beq, is_bne, is_jump, is_jr;
	logic dest_writes, issue;

	assign head    = q_instr[rd_ptr];
	assign head_pc = q_pc[rd_ptr];

	control_unit u_control (
		.opcode     (head.r.opcode),
		.funct      (head.r.funct),
		.alu_op     (alu_op),
		.use_imm    (use_imm),
		.zero_ext   (zero_ext),
		.writes     (writes),
		.dest_is_rd (dest_is_rd),
		.is_beq     (is_beq),
		.is_bne     (is_bne),
		.is_jump    (is_jump),
		.is_jr      (is_jr)
	);

	register_file u_regs (
		.clk       (clk),
		.rst       (rst),
		.rd_addr_a (head.r.rs),
		.rd_addr_b (head.r.rt),
		.wr_en     (wr_en),
		.wr_addr   (wr_dest),
		.wr_data   (wr_data),
		.rd_data_a (rs_data),
		.rd_data_b (rt_data)
	);

	////////////////////
	// Interlock
	////////////////////
	// A release from write-back counts in the same cycle
	assign pending     = wr_en ? (scoreboard & ~(1 << wr_dest)) : scoreboard;
	assign dest        = dest_is_rd ? head.r.rd : head.i.rt;
	assign dest_writes = writes && (dest != '0);
	assign issue       = (q_count != '0) && !hold &&
	                     !(pending[head.r.rs] || pending[head.r.rt] || pending[dest]);
	assign set_mask    = (issue && dest_writes) ? (1 << dest) : '0;

	assign imm_ext  = zero_ext ? {16'b0, head.i.imm} : {{16{head.i.imm[15]}}, head.i.imm};
	assign pc_plus4 = head_pc + 32'd4;

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			q_instr[wr_ptr] <= in_instr;
			q_pc[wr_ptr]    <= in_pc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			q_count    <= '0;
			in_credit  <= 1'b0;
			scoreboard <= '0;
			ex_valid   <= 1'b0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= (wr_ptr == PTR_BITS'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (issue)
				rd_ptr <= (rd_ptr == PTR_BITS'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			q_count    <= q_count + CNT_BITS'(in_valid) - CNT_BITS'(issue);
			in_credit  <= issue;
			scoreboard <= pending | set_mask;
			if (!hold)
				ex_valid <= issue;
		end
	end

	////////////////////
	// Pipeline register
	////////////////////
	always_ff @(posedge clk)
	begin
		if (!hold)
		begin
			ex_alu_op  <= alu_op;
			ex_a       <= rs_data;
			ex_b       <= rt_data;
			ex_use_imm <= use_imm;
			ex_imm     <= imm_ext;
			ex_shamt   <= head.r.shamt;
			ex_dest    <= dest;
			ex_writes  <= dest_writes;
			ex_is_beq  <= is_beq;
			ex_is_bne  <= is_bne;
			ex_is_jump <= is_jump || is_jr;
			if (is_jr)
				ex_target <= rs_data;
			else if (is_jump)
				ex_target <= {pc_plus4[31:28], head.j.index, 2'b00};
			else
				ex_target <= pc_plus4 + (imm_ext << 2);
		end
	end

	// The sender never has more instructions out than there are free entries
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> (q_count < CNT_BITS'(IN_DEPTH)));

	// Write-back only releases a destination that was marked at issue
	a_clear_pending: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> scoreboard[wr_dest]);

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ns

module register_file import mips_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic [REG_BITS-1:0] rd_addr_a,
	input  logic [REG_BITS-1:0] rd_addr_b,
	input  logic                wr_en,
	input  logic [REG_BITS-1:0] wr_addr,
	input  logic [XLEN-1:0]     wr_data,
	output logic [XLEN-1:0]     rd_data_a,
	output logic [XLEN-1:0]     rd_data_b
);

	logic [XLEN-1:0] regs [2**REG_BITS];
	logic            wr_live;

	// r0 is never written, so it keeps its reset value of zero
	assign wr_live = wr_en && (wr_addr != '0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 2**REG_BITS; i++)
				regs[i] <= '0;
		end
		else if (wr_live)
			regs[wr_addr] <= wr_data;
	end

	// Write-through so a same-cycle write is seen at issue
	assign rd_data_a = (wr_live && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (wr_live && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

//--- hw/control_unit.sv
`timescale 1ns/1ns

module control_unit import mips_pkg::*; (
	input  logic [5:0]          opcode,
	input  logic [5:0]          funct,
	output logic [ALU_BITS-1:0] alu_op,
	output logic                use_imm,
	output logic                zero_ext,
	output logic                writes,
	output logic                dest_is_rd,
	output logic                is_beq,
	output logic                is_bne,
	output logic                is_jump,
	output logic                is_jr
);

	always_comb
	begin
		// I-type ALU ops take operand B from the immediate and write rt
		use_imm    = opcode inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
		                            OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
		zero_ext   = opcode inside {OP_ANDI, OP_ORI, OP_XORI};
		writes     = use_imm;
		dest_is_rd = 1'b0;
		is_beq     = (opcode == OP_BEQ);
		is_bne     = (opcode == OP_BNE);
		is_jump    = (opcode == OP_J);
		is_jr      = 1'b0;
		case (opcode)
			OP_SLTI:  alu_op = ALU_SLT;
			OP_SLTIU: alu_op = ALU_SLTU;
			OP_ANDI:  alu_op = ALU_AND;
			OP_ORI:   alu_op = ALU_OR;
			OP_XORI:  alu_op = ALU_XOR;
			OP_LUI:   alu_op = ALU_LUI;
			OP_RTYPE:
			begin
				writes     = 1'b1;
				dest_is_rd = 1'b1;
				case (funct)
					FN_ADD, FN_ADDU: alu_op = ALU_ADD;
					FN_SUB, FN_SUBU: alu_op = ALU_SUB;
					FN_AND:          alu_op = ALU_AND;
					FN_OR:           alu_op = ALU_OR;
					FN_XOR:          alu_op = ALU_XOR;
					FN_NOR:          alu_op = ALU_NOR;
					FN_SLT:          alu_op = ALU_SLT;
					FN_SLTU:         alu_op = ALU_SLTU;
					FN_SLL:          alu_op = ALU_SLL;
					FN_SRL:          alu_op = ALU_SRL;
					FN_SRA:          alu_op = ALU_SRA;
					default:
					begin
						// jr and unknown functs write nothing
						alu_op = ALU_ADD;
						writes = 1'b0;
						is_jr  = (funct == FN_JR);
					end
				endcase
			end
			default:  alu_op = ALU_ADD;
		endcase
	end

endmodule

//--- hw/mips_pkg.sv
package mips_pkg;

	localparam int XLEN     = 32;
	localparam int REG_BITS = 5;
	localparam int ALU_BITS = 4;

	////////////////////
	// Major opcodes
	////////////////////
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_SLTIU = 6'h0b;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_LUI   = 6'h0f;

	// R-type funct field
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_JR   = 6'h08;

	////////////////////
	// ALU operations
	////////////////////
	localparam logic [ALU_BITS-1:0] ALU_ADD  = 4'd0;
	localparam logic [ALU_BITS-1:0] ALU_SUB  = 4'd1;
	localparam logic [ALU_BITS-1:0] ALU_AND  = 4'd2;
	localparam logic [ALU_BITS-1:0] ALU_OR   = 4'd3;
	localparam logic [ALU_BITS-1:0] ALU_XOR  = 4'd4;
	localparam logic [ALU_BITS-1:0] ALU_NOR  = 4'd5;
	localparam logic [ALU_BITS-1:0] ALU_SLT  = 4'd6;
	localparam logic [ALU_BITS-1:0] ALU_SLTU = 4'd7;
	localparam logic [ALU_BITS-1:0] ALU_SLL  = 4'd8;
	localparam logic [ALU_BITS-1:0] ALU_SRL  = 4'd9;
	localparam logic [ALU_BITS-1:0] ALU_SRA  = 4'd10;
	localparam logic [ALU_BITS-1:0] ALU_LUI  = 4'd11;

	// One instruction word seen through the R, I and J layouts
	typedef union packed {
		struct packed {
			logic [5:0]          opcode;
			logic [REG_BITS-1:0] rs;
			logic [REG_BITS-1:0] rt;
			logic [REG_BITS-1:0] rd;
			logic [4:0]          shamt;
			logic [5:0]          funct;
		} r;
		struct packed {
			logic [5:0]          opcode;
			logic [REG_BITS-1:0] rs;
			logic [REG_BITS-1:0] rt;
			logic [15:0]         imm;
		} i;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] index;
		} j;
	} instr_u;

endpackage
